//--- hw/looper_pkg.sv
package looper_pkg;

    localparam int NUM_BANKS       = 8;  // Loop banks
    localparam int BANK_W          = 3;  // Bank index width
    localparam int MAX_W           = 23; // Loop length and position width

    // Small simulation values that a board build raises
    localparam int DEBOUNCE_CYCLES = 4;  // Stable cycles before a level is accepted
    localparam int DEBOUNCE_W      = $clog2(DEBOUNCE_CYCLES);
    localparam int HOLD_CYCLES     = 40; // Stop held this long deletes the bank
    localparam int HOLD_W          = $clog2(HOLD_CYCLES);
    localparam int ERASE_WORDS     = 16; // Sample addresses per bank
    localparam int ERASE_ADDR_W    = 4;

    typedef struct packed {
        logic back;                      // Previous bank
        logic stop;                      // Stop, held for delete
        logic play;                      // Play or record
        logic next;                      // Next bank
    } btn_t;

    typedef struct packed {
        logic [NUM_BANKS-1:0] playing;
        logic [NUM_BANKS-1:0] recording;
        logic [NUM_BANKS-1:0] active;    // Bank holds a recorded loop
    } bank_status_t;

    typedef struct packed {
        logic              delete;       // Level, held until the clear
        logic [BANK_W-1:0] bank;
    } erase_req_t;

    typedef struct packed {
        logic                    strobe; // One sample write of zero
        logic [BANK_W-1:0]       bank;
        logic [ERASE_ADDR_W-1:0] addr;
    } erase_wr_t;

    typedef enum logic [3:0] {
        IDLE, IDLE_DB, PLAY, RECORD, REC_REL, STOP_HOLD, DELETE, DEL_REL, DELETE_OTHERS
    } ctrl_state_e;

endpackage

//--- hw/button_sync.sv
module button_sync import looper_pkg::*; (
    input  logic clk100,
    input  logic rst,
    input  btn_t raw,  // Straight from the board pins
    output btn_t btn   // Clean levels for the FSM
);

    logic [$bits(btn_t)-1:0] meta;                 // First sync stage
    logic [$bits(btn_t)-1:0] sync;                 // Second sync stage
    logic [$bits(btn_t)-1:0] level;                // Accepted level per button
    logic [DEBOUNCE_W-1:0]   cnt [$bits(btn_t)];   // Disagreement run length

    always_ff @(posedge clk100) begin
        if (rst) begin
            meta  <= '0;
            sync  <= '0;
            level <= '0;
            for (int i = 0; i < $bits(btn_t); i++) begin
                cnt[i] <= '0;
            end
        end else begin
            meta <= raw;
            sync <= meta;
            for (int i = 0; i < $bits(btn_t); i++) begin
                if (sync[i] == level[i]) begin
                    cnt[i] <= '0;                  // Bounced back to the accepted level
                end else if (cnt[i] == DEBOUNCE_W'(DEBOUNCE_CYCLES - 1)) begin
                    level[i] <= sync[i];           // Held long enough
                    cnt[i]   <= '0;
                end else begin
                    cnt[i] <= cnt[i] + 1'b1;
                end
            end
        end
    end

    assign btn = btn_t'(level);

endmodule

//--- hw/loop_ctrl.sv
module loop_ctrl import looper_pkg::*; (
    input  logic               clk100,
    input  logic               rst,
    input  btn_t               btn,           // Debounced buttons
    output bank_status_t       status,
    output logic [BANK_W-1:0]  bank,          // Bank the buttons act on
    output erase_req_t         erase,
    input  logic               delete_clear,  // Eraser finished the bank
    input  logic [MAX_W-1:0]   current_max,
    output logic               set_max,       // Latch first loop length
    output logic               reset_max      // Forget loop length
);

    ctrl_state_e          state;
    logic                 others_pending;    // Wipe the other banks after the first loop
    logic [HOLD_W-1:0]    hold_cnt;
    logic                 hold_done;
    logic [BANK_W-1:0]    other_bank;        // Next candidate in DELETE_OTHERS
    logic [NUM_BANKS-1:0] active_left;       // Active mask once this bank is gone

    assign hold_done   = (hold_cnt == HOLD_W'(HOLD_CYCLES - 1));
    assign other_bank  = erase.bank + 1'b1;
    assign active_left = status.active & ~(NUM_BANKS'(1) << bank);

    // Stop-hold timer runs only while stop stays down in STOP_HOLD
    always_ff @(posedge clk100) begin
        if (rst || state != STOP_HOLD) begin
            hold_cnt <= '0;
        end else if (!hold_done) begin
            hold_cnt <= hold_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk100) begin
        if (rst) begin
            state          <= IDLE;
            status         <= '0;
            bank           <= '0;
            erase          <= '0;
            others_pending <= 1'b0;
            set_max        <= 1'b0;
            reset_max      <= 1'b1;              // Max is cleared while in reset
        end else begin
            set_max   <= 1'b0;                   // Both flags are single pulses
            reset_max <= 1'b0;
            if (delete_clear) begin
                erase.delete <= 1'b0;
            end
            case (state)
                IDLE: begin
                    if (btn.back) begin
                        bank  <= bank - 1'b1;    // Wraps 0 to 7
                        state <= IDLE_DB;
                    end else if (btn.next) begin
                        bank  <= bank + 1'b1;
                        state <= IDLE_DB;
                    end else if (btn.stop) begin
                        status.playing[bank] <= 1'b0;  // Stop at once and delete only if held
                        state                <= STOP_HOLD;
                    end else if (btn.play) begin
                        if (status.active[bank] && !status.playing[bank]) begin
                            status.playing[bank]   <= 1'b1;
                            status.recording[bank] <= 1'b0;
                            state                  <= PLAY;
                        end else begin
                            // Empty bank or overdub on a playing one
                            status.recording[bank] <= 1'b1;
                            status.playing[bank]   <= 1'b0;
                            state                  <= RECORD;
                        end
                    end
                end
                IDLE_DB: begin
                    if (btn == '0) begin
                        state <= IDLE;
                    end
                end
                PLAY: begin
                    if (!btn.play) begin
                        others_pending <= 1'b0;
                        state          <= others_pending ? DELETE_OTHERS : IDLE;
                    end
                end
                RECORD: begin
                    if (!btn.play) begin
                        state <= REC_REL;        // Keeps recording after release
                    end else if (btn.stop) begin
                        state <= DELETE;
                    end
                end
                REC_REL: begin
                    if (btn.stop) begin
                        state <= DELETE;         // Abandon the take
                    end else if (btn.play && !erase.delete) begin
                        status.active[bank]    <= 1'b1;
                        status.playing[bank]   <= 1'b1;
                        status.recording[bank] <= 1'b0;
                        if (current_max == '0) begin
                            // First loop sets the length and wipes stale banks
                            set_max        <= 1'b1;
                            erase.bank     <= bank + 1'b1;
                            erase.delete   <= 1'b1;
                            others_pending <= 1'b1;
                        end
                        state <= PLAY;
                    end
                end
                DELETE_OTHERS: begin
                    if (!erase.delete) begin
                        erase.bank <= other_bank;
                        if (status.active[other_bank]) begin
                            state <= IDLE;       // Walked round to the new loop
                        end else begin
                            erase.delete <= 1'b1;
                        end
                    end
                end
                STOP_HOLD: begin
                    if (!btn.stop) begin
                        state <= IDLE;           // Short press only stops
                    end else if (hold_done) begin
                        state <= DELETE;
                    end
                end
                DELETE: begin
                    // Waits out an erase still in flight
                    if (!erase.delete) begin
                        erase.delete           <= 1'b1;
                        erase.bank             <= bank;
                        status.recording[bank] <= 1'b0;
                        status.active[bank]    <= 1'b0;
                        if (active_left == '0) begin
                            reset_max <= 1'b1;   // Last loop gone
                        end
                        state <= DEL_REL;
                    end
                end
                DEL_REL: begin
                    if (btn == '0) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

//--- hw/bank_eraser.sv
module bank_eraser import looper_pkg::*; (
    input  logic       clk100,
    input  logic       rst,
    input  erase_req_t erase,
    output erase_wr_t  wr,
    output logic       delete_clear  // One cycle after the last write
);

    logic                    delete_q;  // Previous delete level for edge detect
    logic                    busy;
    logic [ERASE_ADDR_W-1:0] addr;
    logic [BANK_W-1:0]       bank_q;    // Bank latched at the request

    always_ff @(posedge clk100) begin
        if (rst) begin
            delete_q     <= 1'b0;
            busy         <= 1'b0;
            addr         <= '0;
            delete_clear <= 1'b0;
        end else begin
            delete_q     <= erase.delete;
            delete_clear <= 1'b0;
            if (erase.delete && !delete_q) begin
                busy <= 1'b1;           // New request
                addr <= '0;
            end else if (busy) begin
                addr <= addr + 1'b1;
                if (addr == ERASE_ADDR_W'(ERASE_WORDS - 1)) begin
                    busy         <= 1'b0;
                    delete_clear <= 1'b1;
                end
            end
        end
    end

    // Target bank taken on the rising delete level
    always_ff @(posedge clk100) begin
        if (erase.delete && !delete_q) begin
            bank_q <= erase.bank;
        end
    end

    assign wr.strobe = busy;
    assign wr.bank   = bank_q;
    assign wr.addr   = addr;

endmodule

//--- hw/loop_timer.sv
module loop_timer import looper_pkg::*; (
    input  logic                 clk100,
    input  logic                 rst,
    input  logic                 sample_tick,  // One per audio sample
    input  logic [NUM_BANKS-1:0] recording,
    input  logic                 set_max,
    input  logic                 reset_max,
    output logic [MAX_W-1:0]     current_max,  // Loop length in samples
    output logic [MAX_W-1:0]     position      // Shared playback pointer
);

    logic [MAX_W-1:0] count;   // Samples in the first take so far
    logic             max_set;
    logic             pos_wrap;

    assign max_set  = (current_max != '0);
    assign pos_wrap = (position == current_max - 1'b1);

    always_ff @(posedge clk100) begin
        if (rst || reset_max) begin
            current_max <= '0;
            count       <= '0;
            position    <= '0;
        end else begin
            if (set_max) begin
                current_max <= (count == '0) ? MAX_W'(1) : count;  // Never a zero length
            end else if (!max_set && (|recording) && sample_tick) begin
                count <= count + 1'b1;
            end
            if (max_set && sample_tick) begin
                position <= pos_wrap ? '0 : position + 1'b1;
            end
        end
    end

endmodule

//--- hw/looper_top.sv
module looper_top import looper_pkg::*; (
    input  logic              clk100,
    input  logic              rst,
    input  btn_t              btns,         // Raw board buttons
    input  logic              sample_tick,
    output bank_status_t      status,
    output logic [BANK_W-1:0] bank,
    output erase_wr_t         erase_wr,     // To the sample memory
    output logic [MAX_W-1:0]  current_max,
    output logic [MAX_W-1:0]  position
);

    btn_t       btn_db;
    erase_req_t erase_req;
    logic       delete_clear;
    logic       set_max;
    logic       reset_max;

    button_sync u_button_sync (
        .clk100 (clk100),
        .rst    (rst),
        .raw    (btns),
        .btn    (btn_db)
    );

    loop_ctrl u_loop_ctrl (
        .clk100       (clk100),
        .rst          (rst),
        .btn          (btn_db),
        .status       (status),
        .bank         (bank),
        .erase        (erase_req),
        .delete_clear (delete_clear),
        .current_max  (current_max),
        .set_max      (set_max),
        .reset_max    (reset_max)
    );

    bank_eraser u_bank_eraser (
        .clk100       (clk100),
        .rst          (rst),
        .erase        (erase_req),
        .wr           (erase_wr),
        .delete_clear (delete_clear)
    );

    loop_timer u_loop_timer (
        .clk100      (clk100),
        .rst         (rst),
        .sample_tick (sample_tick),
        .recording   (status.recording),
        .set_max     (set_max),
        .reset_max   (reset_max),
        .current_max (current_max),
        .position    (position)
    );

endmodule

//--- bench/looper_sva.sv
module looper_sva import looper_pkg::*; (
    input logic       clk100,
    input logic       rst,
    input erase_req_t erase,         // Controller request to the eraser
    input logic       strobe,        // Eraser write strobe
    input logic       delete_clear,
    input logic       set_max,
    input logic       reset_max
);

    int fail_count = 0;              // Read by the testbench at the end

    a_strobe_needs_delete: assert property (@(posedge clk100) disable iff (rst)
        strobe |-> erase.delete)
        else begin
            $error("erase strobe while delete is low");
            fail_count++;
        end

    a_clear_one_cycle: assert property (@(posedge clk100) disable iff (rst)
        delete_clear |=> !delete_clear)
        else begin
            $error("delete_clear held longer than one cycle");
            fail_count++;
        end

    a_max_flags_apart: assert property (@(posedge clk100) disable iff (rst)
        !(set_max && reset_max))
        else begin
            $error("set_max and reset_max high together");
            fail_count++;
        end

    a_bank_held: assert property (@(posedge clk100) disable iff (rst)
        erase.delete ##1 erase.delete |-> $stable(erase.bank))
        else begin
            $error("erase bank changed during a delete");
            fail_count++;
        end

endmodule

// Watches the controller to eraser link inside the top level
bind looper_top looper_sva u_looper_sva (
    .clk100       (clk100),
    .rst          (rst),
    .erase        (erase_req),
    .strobe       (erase_wr.strobe),
    .delete_clear (delete_clear),
    .set_max      (set_max),
    .reset_max    (reset_max)
);

//--- bench/looper_tb.sv
module looper_tb import looper_pkg::*; ();

    logic                 clk100;
    logic                 rst;
    btn_t                 btns;
    logic                 sample_tick;
    bank_status_t         status;
    logic [BANK_W-1:0]    bank;
    erase_wr_t            erase_wr;
    logic [MAX_W-1:0]     current_max;
    logic [MAX_W-1:0]     position;

    logic [31:0]          lfsr;          // Random source stepped once per bit
    int                   errors;
    int                   checks;
    int                   tests;
    int                   err_start;     // Error count when the action began
    int                   strobe_cnt;    // Erase writes seen in this action
    logic [NUM_BANKS-1:0] strobe_banks;  // Banks those writes hit
    logic                 timed_out;
    bank_status_t         exp_status;    // Model state
    logic [BANK_W-1:0]    exp_bank;
    logic                 exp_max_set;   // First loop length is latched
    int                   exp_strobes;
    logic [NUM_BANKS-1:0] exp_banks;
    logic [2:0]           act;
    string                kind;

    looper_top u_looper_top (
        .clk100      (clk100),
        .rst         (rst),
        .btns        (btns),
        .sample_tick (sample_tick),
        .status      (status),
        .bank        (bank),
        .erase_wr    (erase_wr),
        .current_max (current_max),
        .position    (position)
    );

    initial begin
        clk100 = 1'b0;
        forever #4 clk100 = ~clk100;
    end

    // Galois form of x^32 + x^22 + x^2 + x + 1
    function logic lfsr_bit();
        logic b;
        b    = lfsr[0];
        lfsr = {1'b0, lfsr[31:1]} ^ (b ? 32'h8020_0003 : 32'h0);
        return b;
    endfunction

    function logic [2:0] rand3();
        logic [2:0] v;
        v = '0;
        for (int k = 0; k < 3; k++) begin
            v = {v[1:0], lfsr_bit()};
        end
        return v;
    endfunction

    task check(input string name, input logic [31:0] expected, input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("Fail %s: expected %h, got %h", name, expected, actual);
        end
    endtask

    // One clock with inputs moved 1 unit after the edge and erase writes tallied
    task step_clock();
        @(posedge clk100);
        #1;
        sample_tick = lfsr_bit();
        if (erase_wr.strobe) begin
            check("erase_wr.addr", 32'(strobe_cnt % ERASE_WORDS), 32'(erase_wr.addr));
            strobe_cnt++;
            strobe_banks[erase_wr.bank] = 1'b1;
        end
    endtask

    task run_cycles(input int n);
        for (int k = 0; k < n; k++) begin
            step_clock();
        end
    endtask

    task press(input btn_t b, input int hold);
        btns = b;
        run_cycles(hold);                // Well past the debounce
        btns = '0;
        run_cycles(12);
    endtask

    // Erase gaps are 3 cycles, so 16 quiet cycles mean the FSM is back in IDLE
    task wait_erase_idle();
        int quiet;
        int n;
        quiet = 0;
        n     = 0;
        while (quiet < 16 && n < 3000) begin
            step_clock();
            quiet = erase_wr.strobe ? 0 : quiet + 1;
            n++;
        end
        if (quiet < 16) begin
            $display("Timeout: erase writes were still running after 3000 cycles");
            errors++;
            timed_out = 1'b1;
        end
    endtask

    task compare_state();
        check("bank", 32'(exp_bank), 32'(bank));
        check("status", {8'h00, exp_status}, {8'h00, status});
        check("erase_wr.strobe count", 32'(exp_strobes), 32'(strobe_cnt));
        check("erase_wr.bank mask", 32'(exp_banks), 32'(strobe_banks));
        if (exp_max_set) begin
            check("current_max nonzero", 32'(1), 32'(current_max != '0));
            check("position below current_max", 32'(1), 32'(position < current_max));
        end else begin
            check("current_max", 32'(0), 32'(current_max));
            check("position", 32'(0), 32'(position));
        end
    endtask

    initial begin
        lfsr         = 32'h1e21_0e3a;
        rst          = 1'b1;
        btns         = '0;
        sample_tick  = 1'b0;
        errors       = 0;
        checks       = 0;
        tests        = 0;
        timed_out    = 1'b0;
        strobe_cnt   = 0;
        strobe_banks = '0;
        exp_status   = '0;
        exp_bank     = '0;
        exp_max_set  = 1'b0;
        repeat (5) @(posedge clk100);
        #1;
        rst = 1'b0;
        run_cycles(4);
        for (int i = 0; i < 60 && !timed_out; i++) begin
            act = rand3();
            if (act > 3'd5) begin
                act = act - 3'd6;                // Spare codes go to navigation
            end
            strobe_cnt   = 0;
            strobe_banks = '0;
            exp_strobes  = 0;
            exp_banks    = '0;
            err_start    = errors;
            case (act)
                3'd0: begin
                    kind = "next";
                    press(btn_t'(4'b0001), 12);
                    exp_bank = exp_bank + 1'b1;  // Wraps 7 to 0
                end
                3'd1: begin
                    kind = "back";
                    press(btn_t'(4'b1000), 12);
                    exp_bank = exp_bank - 1'b1;
                end
                3'd2, 3'd3: begin
                    // A stopped loop only restarts and anything else is recorded
                    if (exp_status.active[exp_bank] && !exp_status.playing[exp_bank]) begin
                        kind = "short play";
                        press(btn_t'(4'b0010), 12);
                    end else begin
                        kind = "record then play";
                        press(btn_t'(4'b0010), 12);
                        press(btn_t'(4'b0010), 12);
                        if (!exp_max_set) begin
                            exp_strobes = (NUM_BANKS - 1) * ERASE_WORDS;  // All other banks
                            exp_banks   = ~(NUM_BANKS'(1) << exp_bank);
                            exp_max_set = 1'b1;
                        end
                        exp_status.active[exp_bank] = 1'b1;
                    end
                    exp_status.playing[exp_bank] = 1'b1;
                end
                3'd4: begin
                    kind = "short stop";
                    press(btn_t'(4'b0100), 12);
                    exp_status.playing[exp_bank] = 1'b0;
                end
                default: begin
                    kind = "long stop";
                    press(btn_t'(4'b0100), HOLD_CYCLES + 20);
                    exp_status.playing[exp_bank]   = 1'b0;
                    exp_status.recording[exp_bank] = 1'b0;
                    exp_status.active[exp_bank]    = 1'b0;
                    exp_strobes = ERASE_WORDS;
                    exp_banks   = NUM_BANKS'(1) << exp_bank;
                    if (exp_status.active == '0) begin
                        exp_max_set = 1'b0;      // Last loop gone so the length is forgotten
                    end
                end
            endcase
            wait_erase_idle();
            compare_state();
            tests++;
            $display("test %0d %s: %s", i, kind, (errors == err_start) ? "ok" : "mismatch");
        end
        errors = errors + u_looper_top.u_looper_sva.fail_count;
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- all.f
hw/looper_pkg.sv
hw/button_sync.sv
hw/loop_ctrl.sv
hw/bank_eraser.sv
hw/loop_timer.sv
hw/looper_top.sv
bench/looper_sva.sv
bench/looper_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= looper_tb
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f all.f
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx 'Test passed'

clean:
	rm -rf $(OBJ_DIR)
